//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                                             soc_clk_i,
  input  logic                                             rst_n_i,
  input  logic                                             soc_rst_n_i,
  input  logic [board_pkg::FAN_SETTING_W-1:0]              fan_sw_i,
  input  logic                                             fan_pwm_i,
  input  logic                                             rtc_i,
  input  board_pkg::spi_pads_t                             spi_i,
  input  logic                                             sd_dat0_i,
  input  board_pkg::sd_pads_t                              sd_i,
  input  logic [board_pkg::SPI_SD_N-1:0]                   spi_sd_i,
  input  regbus_pkg::reg_req_t [regbus_pkg::REG_PORTS-1:0] conf_req_i,
  input  regbus_pkg::reg_rsp_t [regbus_pkg::REG_PORTS-1:0] conf_rsp_i,
  input  logic                                             fan_on_i,
  input  logic                                             fan_win_i,
  input  logic                                             pads_on_i,
  input  logic                                             miso_on_i,
  input  logic                                             reg_on_i,
  output logic                                             paced_done_o,
  output int                                               tests_run_o,
  output int                                               tests_failed_o,
  output int                                               checks_o,
  output int                                               errors_o
);
  import board_pkg::*;
  import regbus_pkg::*;

  localparam int N_TESTS   = 6;
  localparam int T_RESET   = 0;
  localparam int T_RTC     = 1;
  localparam int T_FAN     = 2;
  localparam int T_PADS    = 3;
  localparam int T_MISO    = 4;
  localparam int T_REG     = 5;
  // rtc edges to time before the test is closed
  localparam int RTC_EDGES = 8;

  int unsigned cyc = 0;
  int          test_checks [N_TESTS] = '{default: 0};
  int          test_errs   [N_TESTS] = '{default: 0};
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          check_total  = 0;
  int          err_total    = 0;

  // reset and rtc tracking
  logic        rst_seen     = 1'b0;
  logic        rst_reported = 1'b0;
  int unsigned rst_seen_cyc = 0;
  logic        rtc_prev     = 1'b0;
  logic        rtc_reported = 1'b0;
  int unsigned rtc_last_cyc = 0;
  int          rtc_edges    = 0;

  // fan window and phase history
  int                       fan_high = 0;
  logic [FAN_SETTING_W-1:0] fan_setting = '0;
  logic                     fan_win_prev = 1'b0;
  logic                     fan_on_prev  = 1'b0;
  logic                     pads_on_prev = 1'b0;
  logic                     miso_on_prev = 1'b0;
  logic                     reg_on_prev  = 1'b0;
  // dat0 as seen on the last two falling edges
  logic [1:0]               miso_hist = '0;

  ////////////////////
  // reference model
  ////////////////////

  // a pad idles high unless its enable is set
  function automatic sd_pads_t exp_sd_pads(input spi_pads_t s);
    sd_pads_t p;
    p.sclk       = s.sck | ~s.sck_en;
    p.dat3       = s.csb[0] | ~s.csb_en[0];
    p.cmd        = s.sd_out[0] | ~s.sd_en[0];
    p.dat21      = '1;
    p.card_reset = 1'b0;
    return p;
  endfunction

  // high cycles per 64 cycle period
  function automatic int exp_fan_high(input logic [FAN_SETTING_W-1:0] setting);
    return int'(setting) * int'(FAN_PRESCALE);
  endfunction

  function automatic logic [SPI_SD_N-1:0] exp_spi_sd(input logic miso);
    logic [SPI_SD_N-1:0] v;
    v            = '0;
    v[MISO_LANE] = miso;
    return v;
  endfunction

  // error answer only while valid
  function automatic reg_rsp_t exp_reg_rsp(input reg_req_t r);
    reg_rsp_t rsp;
    rsp.rdata = r.valid ? REG_ERR_VAL : '0;
    rsp.error = r.valid;
    rsp.ready = r.valid;
    return rsp;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      T_RESET: return "reset_hold";
      T_RTC:   return "rtc_clock";
      T_FAN:   return "fan_pwm";
      T_PADS:  return "sd_pads";
      T_MISO:  return "miso_sync";
      default: return "reg_err";
    endcase
  endfunction

  ////////////////////
  // bookkeeping
  ////////////////////

  task automatic check_val(input int t, input string what, input logic [63:0] exp,
                           input logic [63:0] act);
    test_checks[t]++;
    check_total++;
    if (exp !== act) begin
      test_errs[t]++;
      err_total++;
      $display("ERR %s%s expected 0x%0h actual 0x%0h", test_name(t), what, exp, act);
    end
  endtask

  task automatic finish_test(input int t);
    tests_run++;
    if (test_errs[t] != 0) begin
      tests_failed++;
    end
    $display("test %-10s checks=%0d errors=%0d %s", test_name(t), test_checks[t],
             test_errs[t], (test_errs[t] == 0) ? "ok" : "failed");
  endtask

  always @(posedge soc_clk_i) begin
    cyc <= cyc + 1;
  end

  ////////////////////
  // compare
  ////////////////////

  // falling edge, every input settled since the rising edge
  always @(negedge soc_clk_i) begin
    if (!rst_reported) begin
      if (!soc_rst_n_i) begin
        // fan, rtc and miso lane stay quiet in reset
        check_val(T_RESET, " idle outputs", 64'(0), 64'({fan_pwm_i, rtc_i, spi_sd_i}));
        if (rst_n_i && !rst_seen) begin
          rst_seen     = 1'b1;
          rst_seen_cyc = cyc;
        end
      end else begin
        // first edge that sees rst_n high is one cycle after the drive
        check_val(T_RESET, " release cycle", 64'(rst_seen_cyc + 1 + RST_HOLD_CYCLES),
                  64'(cyc));
        rst_reported = 1'b1;
        rtc_last_cyc = cyc;
        finish_test(T_RESET);
      end
    end

    // rtc timed from the soc reset release
    if (rst_reported && !rtc_reported) begin
      if (rtc_i != rtc_prev) begin
        check_val(T_RTC, " edge spacing", 64'(RTC_HALF_PERIOD), 64'(cyc - rtc_last_cyc));
        rtc_prev     = rtc_i;
        rtc_last_cyc = cyc;
        rtc_edges++;
      end else if (cyc - rtc_last_cyc > RTC_HALF_PERIOD) begin
        $display("rtc_clock: rtc_o did not toggle within %0d cycles", RTC_HALF_PERIOD);
        test_errs[T_RTC]++;
        err_total++;
        rtc_last_cyc = cyc;
        rtc_edges++;
      end
      if (rtc_edges == RTC_EDGES) begin
        rtc_reported = 1'b1;
        finish_test(T_RTC);
      end
    end

    // fan high count over one window
    if (fan_win_i) begin
      if (!fan_win_prev) begin
        fan_high = 0;
      end
      fan_setting = fan_sw_i;
      if (fan_pwm_i) begin
        fan_high++;
      end
    end else if (fan_win_prev) begin
      check_val(T_FAN, $sformatf(" setting %0d", fan_setting),
                64'(exp_fan_high(fan_setting)), 64'(fan_high));
    end

    if (pads_on_i) begin
      check_val(T_PADS, "", 64'(exp_sd_pads(spi_i)), 64'(sd_i));
    end

    // lane 1 shows dat0 from two edges back
    if (miso_on_i) begin
      check_val(T_MISO, "", 64'(exp_spi_sd(miso_hist[1])), 64'(spi_sd_i));
    end
    miso_hist = {miso_hist[0], sd_dat0_i};

    if (reg_on_i) begin
      for (int unsigned p = 0; p < REG_PORTS; p++) begin
        check_val(T_REG, $sformatf(" port%0d", p), 64'(exp_reg_rsp(conf_req_i[p])),
                  64'(conf_rsp_i[p]));
      end
    end

    // a falling phase flag closes its test
    if (fan_on_prev && !fan_on_i) begin
      finish_test(T_FAN);
    end
    if (pads_on_prev && !pads_on_i) begin
      finish_test(T_PADS);
    end
    if (miso_on_prev && !miso_on_i) begin
      finish_test(T_MISO);
    end
    if (reg_on_prev && !reg_on_i) begin
      finish_test(T_REG);
    end
    fan_win_prev = fan_win_i;
    fan_on_prev  = fan_on_i;
    pads_on_prev = pads_on_i;
    miso_on_prev = miso_on_i;
    reg_on_prev  = reg_on_i;
  end

  assign paced_done_o   = rst_reported && rtc_reported;
  assign tests_run_o    = tests_run;
  assign tests_failed_o = tests_failed;
  assign checks_o       = check_total;
  assign errors_o       = err_total;

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import board_pkg::*;
  import regbus_pkg::*;

  localparam int unsigned SEED        = 32'hed21cbbe;
  localparam int          CLK_HALF    = 5;
  localparam int          RST_CYCLES  = 10;
  localparam int          N_TESTS     = 6;
  localparam int          FAN_RUNS    = 6;
  localparam int          PAD_CYCLES  = 200;
  localparam int          MISO_CYCLES = 200;
  localparam int          REG_CYCLES  = 100;
  localparam int          FAN_PERIOD  = FAN_PRESCALE * FAN_STEPS;
  // fan run is one settle period plus one measured period
  localparam int          RUN_CYCLES  = RST_CYCLES + RST_HOLD_CYCLES
                                        + FAN_RUNS * (2 * FAN_PERIOD + 1)
                                        + PAD_CYCLES + MISO_CYCLES + REG_CYCLES;
  localparam int          WATCHDOG_CYCLES = 2 * RUN_CYCLES + 100;

  logic                     soc_clk = 1'b0;
  logic                     rst_n;
  logic                     soc_rst_no;
  logic [FAN_SETTING_W-1:0] fan_sw;
  logic                     fan_pwm;
  logic                     rtc;
  spi_pads_t                spi;
  logic                     sd_dat0;
  sd_pads_t                 sd;
  logic [SPI_SD_N-1:0]      spi_sd;
  reg_req_t [REG_PORTS-1:0] conf_req;
  reg_rsp_t [REG_PORTS-1:0] conf_rsp;

  // phase flags towards the checker
  logic fan_on;
  logic fan_win;
  logic pads_on;
  logic miso_on;
  logic reg_on;
  logic paced_done;
  int   tests_run;
  int   tests_failed;
  int   checks;
  int   errors;

  always #CLK_HALF soc_clk = ~soc_clk;

  board_glue_top i_dut (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( rst_n      ),
    .soc_rst_no ( soc_rst_no ),
    .fan_sw_i   ( fan_sw     ),
    .fan_pwm_o  ( fan_pwm    ),
    .rtc_o      ( rtc        ),
    .spi_i      ( spi        ),
    .sd_dat0_i  ( sd_dat0    ),
    .sd_o       ( sd         ),
    .spi_sd_o   ( spi_sd     ),
    .conf_req_i ( conf_req   ),
    .conf_rsp_o ( conf_rsp   )
  );

  tb_checker i_checker (
    .soc_clk_i      ( soc_clk      ),
    .rst_n_i        ( rst_n        ),
    .soc_rst_n_i    ( soc_rst_no   ),
    .fan_sw_i       ( fan_sw       ),
    .fan_pwm_i      ( fan_pwm      ),
    .rtc_i          ( rtc          ),
    .spi_i          ( spi          ),
    .sd_dat0_i      ( sd_dat0      ),
    .sd_i           ( sd           ),
    .spi_sd_i       ( spi_sd       ),
    .conf_req_i     ( conf_req     ),
    .conf_rsp_i     ( conf_rsp     ),
    .fan_on_i       ( fan_on       ),
    .fan_win_i      ( fan_win      ),
    .pads_on_i      ( pads_on      ),
    .miso_on_i      ( miso_on      ),
    .reg_on_i       ( reg_on       ),
    .paced_done_o   ( paced_done   ),
    .tests_run_o    ( tests_run    ),
    .tests_failed_o ( tests_failed ),
    .checks_o       ( checks       ),
    .errors_o       ( errors       )
  );

  ////////////////////
  // random stimulus
  ////////////////////

  function automatic spi_pads_t rand_spi();
    logic [31:0] word;
    word = $urandom;
    return spi_pads_t'(word[$bits(spi_pads_t)-1:0]);
  endfunction

  // valid is a coin toss so idle ports get checked too
  function automatic reg_req_t rand_req();
    reg_req_t r;
    r.addr  = {16'($urandom), $urandom};
    r.write = 1'($urandom);
    r.wdata = $urandom;
    r.wstrb = 4'($urandom);
    r.valid = 1'($urandom);
    return r;
  endfunction

  ////////////////////
  // tests
  ////////////////////

  task automatic run_fan_test();
    logic [FAN_SETTING_W-1:0] setting;
    for (int n = 0; n < FAN_RUNS; n++) begin
      // both ends of the range first
      if (n == 0) begin
        setting = '0;
      end else if (n == 1) begin
        setting = '1;
      end else begin
        setting = FAN_SETTING_W'($urandom);
      end
      @(posedge soc_clk);
      fan_on <= 1'b1;
      fan_sw <= setting;
      // a period boundary latches it within one period
      repeat (FAN_PERIOD) @(posedge soc_clk);
      fan_win <= 1'b1;
      repeat (FAN_PERIOD) @(posedge soc_clk);
      fan_win <= 1'b0;
    end
    @(posedge soc_clk);
    fan_on <= 1'b0;
  endtask

  task automatic run_pad_test();
    repeat (PAD_CYCLES) begin
      @(posedge soc_clk);
      pads_on <= 1'b1;
      spi     <= rand_spi();
    end
    @(posedge soc_clk);
    pads_on <= 1'b0;
  endtask

  task automatic run_miso_test();
    repeat (MISO_CYCLES) begin
      @(posedge soc_clk);
      miso_on <= 1'b1;
      sd_dat0 <= 1'($urandom);
    end
    @(posedge soc_clk);
    miso_on <= 1'b0;
  endtask

  task automatic run_reg_test();
    repeat (REG_CYCLES) begin
      @(posedge soc_clk);
      reg_on <= 1'b1;
      for (int p = 0; p < REG_PORTS; p++) begin
        conf_req[p] <= rand_req();
      end
    end
    @(posedge soc_clk);
    reg_on <= 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n    = 1'b0;
    // switches at full and dat0 high while the soc reset is held
    fan_sw   = '1;
    spi      = '0;
    sd_dat0  = 1'b1;
    conf_req = '0;
    fan_on   = 1'b0;
    fan_win  = 1'b0;
    pads_on  = 1'b0;
    miso_on  = 1'b0;
    reg_on   = 1'b0;
    repeat (RST_CYCLES) @(posedge soc_clk);
    rst_n <= 1'b1;
    // soc side starts once the held reset is gone
    wait (soc_rst_no);
    @(posedge soc_clk);
    run_fan_test();
    run_pad_test();
    run_miso_test();
    run_reg_test();
    // reset and rtc are paced by the DUT itself
    wait (paced_done);
    repeat (2) @(posedge soc_clk);
    $display("tests=%0d failed=%0d checks=%0d errors=%0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0 && tests_failed == 0 && tests_run == N_TESTS) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the board glue testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_top_sim
LOG=sim.log
PASS_MSG="Simulation finished: PASS"

if ! command -v verilator >/dev/null 2>&1; then
  echo "run_sim: verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -f tb.f --top-module tb_top --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "run_sim: build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

# the log decides, not the exit status alone
if grep -qxF "$PASS_MSG" "$LOG"; then
  echo "run_sim: passed"
  exit 0
fi

echo "run_sim: failed, see $LOG"
exit 1

//--- src/board_glue_top.sv
`timescale 1ns/1ps

module board_glue_top (
  input  logic                                             soc_clk,
  input  logic                                             rst_n,
  output logic                                             soc_rst_no,
  input  logic [board_pkg::FAN_SETTING_W-1:0]               fan_sw_i,
  output logic                                             fan_pwm_o,
  output logic                                             rtc_o,
  input  board_pkg::spi_pads_t                             spi_i,
  input  logic                                             sd_dat0_i,
  output board_pkg::sd_pads_t                              sd_o,
  output logic [board_pkg::SPI_SD_N-1:0]                    spi_sd_o,
  input  regbus_pkg::reg_req_t [regbus_pkg::REG_PORTS-1:0] conf_req_i,
  output regbus_pkg::reg_rsp_t [regbus_pkg::REG_PORTS-1:0] conf_rsp_o
);

  // held soc reset for everything below
  logic soc_rst_n;

  ////////////////////
  // reset
  ////////////////////

  rst_gen i_rst_gen (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( rst_n      ),
    .soc_rst_no ( soc_rst_n  )
  );

  // same reset goes out to the soc
  assign soc_rst_no = soc_rst_n;

  ////////////////////
  // rtc
  ////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  ////////////////////
  // fan control
  ////////////////////

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .setting_i ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  ////////////////////
  // sd card over spi
  ////////////////////

  sd_spi_pads i_sd_spi_pads (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( soc_rst_n ),
    .spi_i     ( spi_i     ),
    .sd_dat0_i ( sd_dat0_i ),
    .sd_o      ( sd_o      ),
    .spi_sd_o  ( spi_sd_o  )
  );

  ////////////////////
  // config ports
  ////////////////////

  // dram, fll and pad config all answer with an error
  reg_err_resp i_reg_err_resp (
    .req_i ( conf_req_i ),
    .rsp_o ( conf_rsp_o )
  );

endmodule

//--- src/board_pkg.sv
package board_pkg;

  ////////////////////
  // timing
  ////////////////////

  // soc_clk cycles per rtc level for a 1 MHz rtc
  localparam int unsigned RTC_HALF_PERIOD = 25;
  localparam int unsigned RTC_CNT_W       = $clog2(RTC_HALF_PERIOD);
  // soc reset hold after board reset release
  localparam int unsigned RST_HOLD_CYCLES = 8;
  localparam int unsigned RST_CNT_W       = $clog2(RST_HOLD_CYCLES);

  // fan pwm, one period is prescale times steps
  localparam int unsigned FAN_SETTING_W   = 4;
  localparam int unsigned FAN_PRESCALE    = 4;
  localparam int unsigned FAN_PRE_W       = $clog2(FAN_PRESCALE);
  localparam int unsigned FAN_STEPS       = 16;

  ////////////////////
  // pads
  ////////////////////

  localparam int unsigned SPI_CS_N        = 2;
  localparam int unsigned SPI_SD_N        = 4;
  // sd dat0 comes back on this lane
  localparam int unsigned MISO_LANE       = 1;

  // soc side of the spi master
  typedef struct packed {
    logic                sck;
    logic                sck_en;
    logic [SPI_CS_N-1:0] csb;
    logic [SPI_CS_N-1:0] csb_en;
    logic [SPI_SD_N-1:0] sd_out;
    logic [SPI_SD_N-1:0] sd_en;
  } spi_pads_t;

  // sd card output pins in spi mode
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic       dat3;
    logic [1:0] dat21;
    logic       card_reset;
  } sd_pads_t;

endpackage

//--- src/fan_pwm.sv
`timescale 1ns/1ps

module fan_pwm (
  input  logic                               soc_clk,
  input  logic                               rst_n,
  input  logic [board_pkg::FAN_SETTING_W-1:0] setting_i,
  output logic                               fan_pwm_o
);
  import board_pkg::*;

  // prescaler and step position inside one period
  logic [FAN_PRE_W-1:0]     pre_q;
  logic [FAN_SETTING_W-1:0] step_q;
  // setting used for the running period
  logic [FAN_SETTING_W-1:0] setting_q;

  logic pre_wrap;
  logic step_wrap;

  assign pre_wrap  = (pre_q == FAN_PRE_W'(FAN_PRESCALE - 1));
  assign step_wrap = pre_wrap && (step_q == FAN_SETTING_W'(FAN_STEPS - 1));

  ////////////////////
  // counters
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q  <= '0;
      step_q <= '0;
    end else begin
      pre_q <= pre_wrap ? '0 : pre_q + 1'b1;
      // one step per prescaler wrap
      if (pre_wrap) begin
        step_q <= step_wrap ? '0 : step_q + 1'b1;
      end
    end
  end

  // new setting only at the period boundary
  // so a period never gets cut short
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      setting_q <= '0;
    end else if (step_wrap) begin
      setting_q <= setting_i;
    end
  end

  ////////////////////
  // output
  ////////////////////

  // high cycles sit at the start of the period
  assign fan_pwm_o = (step_q < setting_q);

endmodule

//--- src/reg_err_resp.sv
`timescale 1ns/1ps

module reg_err_resp (
  input  regbus_pkg::reg_req_t [regbus_pkg::REG_PORTS-1:0] req_i,
  output regbus_pkg::reg_rsp_t [regbus_pkg::REG_PORTS-1:0] rsp_o
);
  import regbus_pkg::*;

  ////////////////////
  // error answer
  ////////////////////

  // every port answers the same way
  // no state and no back-pressure
  always_comb begin
    for (int unsigned i = 0; i < REG_PORTS; i++) begin
      // idle port returns all zero
      rsp_o[i] = '0;
      if (req_i[i].valid) begin
        // accept at once and flag the error
        rsp_o[i].ready = 1'b1;
        rsp_o[i].error = 1'b1;
        // fixed read value for reads and writes alike
        rsp_o[i].rdata = REG_ERR_VAL;
      end
    end
  end

endmodule

//--- src/regbus_pkg.sv
package regbus_pkg;

  ////////////////////
  // register bus
  ////////////////////

  localparam int unsigned REG_ADDR_W = 48;
  localparam int unsigned REG_DATA_W = 32;
  // read value of every unused config port
  localparam logic [REG_DATA_W-1:0] REG_ERR_VAL = 32'hbadcab1e;
  // dram, fll and pad config ports
  localparam int unsigned REG_PORTS  = 3;

  typedef struct packed {
    logic [REG_ADDR_W-1:0]   addr;
    logic                    write;
    logic [REG_DATA_W-1:0]   wdata;
    logic [REG_DATA_W/8-1:0] wstrb;
    logic                    valid;
  } reg_req_t;

  // ready comes back in the request cycle
  typedef struct packed {
    logic [REG_DATA_W-1:0] rdata;
    logic                  error;
    logic                  ready;
  } reg_rsp_t;

endpackage

//--- src/rst_gen.sv
`timescale 1ns/1ps

module rst_gen (
  input  logic soc_clk,
  input  logic rst_n,
  output logic soc_rst_no
);
  import board_pkg::*;

  // release path of the board reset
  logic [1:0]           sync_q;
  // hold counter, runs once sync_q[1] is set
  logic [RST_CNT_W-1:0] cnt_q;
  logic                 rst_q;

  ////////////////////
  // synchronizer
  ////////////////////

  // assert is async, release walks through two flops
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  ////////////////////
  // hold counter
  ////////////////////

  // two sync cycles are part of the hold time
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rst_q <= 1'b0;
    end else if (sync_q[1] && !rst_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == RST_CNT_W'(RST_HOLD_CYCLES - 2)) begin
        rst_q <= 1'b1;
      end
    end
  end

  assign soc_rst_no = rst_q;

endmodule

//--- src/rtc_divider.sv
`timescale 1ns/1ps

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);
  import board_pkg::*;

  logic [RTC_CNT_W-1:0] cnt_d, cnt_q;
  logic                 rtc_d, rtc_q;

  // count up to half period minus one
  // then wrap and flip the level
  always_comb begin
    cnt_d = cnt_q + 1'b1;
    rtc_d = rtc_q;
    if (cnt_q == RTC_CNT_W'(RTC_HALF_PERIOD - 1)) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  // rtc starts low out of soc reset
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  // level goes straight to the pin
  assign rtc_o = rtc_q;

endmodule

//--- src/sd_spi_pads.sv
`timescale 1ns/1ps

module sd_spi_pads (
  input  logic                          soc_clk,
  input  logic                          rst_n,
  input  board_pkg::spi_pads_t          spi_i,
  input  logic                          sd_dat0_i,
  output board_pkg::sd_pads_t           sd_o,
  output logic [board_pkg::SPI_SD_N-1:0] spi_sd_o
);
  import board_pkg::*;

  // dat0 comes from the card clock domain
  logic [1:0] miso_q;

  ////////////////////
  // pad mapping
  ////////////////////

  always_comb begin
    // sck onto sd clk, idle high
    sd_o.sclk       = spi_i.sck_en ? spi_i.sck : 1'b1;
    // chip select 0 drives dat3
    sd_o.dat3       = spi_i.csb_en[0] ? spi_i.csb[0] : 1'b1;
    // mosi on lane 0 drives cmd
    sd_o.cmd        = spi_i.sd_en[0] ? spi_i.sd_out[0] : 1'b1;
    // dat1 and dat2 unused in spi mode
    sd_o.dat21      = 2'b11;
    // held low to keep the card powered
    sd_o.card_reset = 1'b0;
  end

  ////////////////////
  // miso return
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      miso_q <= '0;
    end else begin
      miso_q <= {miso_q[0], sd_dat0_i};
    end
  end

  // only the miso lane carries data back
  always_comb begin
    spi_sd_o            = '0;
    spi_sd_o[MISO_LANE] = miso_q[1];
  end

endmodule

//--- tb.f
src/board_pkg.sv
src/regbus_pkg.sv
src/rst_gen.sv
src/rtc_divider.sv
src/fan_pwm.sv
src/sd_spi_pads.sv
src/reg_err_resp.sv
src/board_glue_top.sv
bench/tb_checker.sv
bench/tb_top.sv
